/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = adc_capture_tb
FILELIST  = adc_capture.f
BUILD_DIR = obj_dir

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(BUILD_DIR)

/* adc_capture.f */
logic/adc_capture_pkg.sv
logic/buffer_port_if.sv
logic/capture_control.sv
logic/sample_select.sv
logic/buffer_sequencer.sv
logic/sample_buffer.sv
logic/frame_packer.sv
logic/overrange_monitor.sv
logic/adc_capture_top.sv
sim/adc_capture_tb.sv

/* logic/adc_capture_pkg.sv */
package adc_capture_pkg;

  // one signed ADC sample
  typedef logic signed [7:0] sample_t;

  // four samples of one channel in one clock, lane 0 in the top byte
  typedef union packed {
    sample_t [0:3] lanes;
    logic [31:0]   raw;
  } sample_word_u;

  // capture controller phases
  localparam logic [1:0] CAP_IDLE    = 2'd0;
  localparam logic [1:0] CAP_WRITE   = 2'd1;
  localparam logic [1:0] CAP_READ    = 2'd2;
  localparam logic [1:0] CAP_BACKOFF = 2'd3;

  // cycles from a buffer read strobe to its data
  localparam int BUF_LATENCY = 2;

  // buffer source codes
  localparam logic [1:0] SRC_ADC0_I = 2'd0;
  localparam logic [1:0] SRC_ADC0_Q = 2'd1;
  localparam logic [1:0] SRC_ADC1_I = 2'd2;
  localparam logic [1:0] SRC_ADC1_Q = 2'd3;

endpackage

/* logic/adc_capture_top.sv */
module adc_capture_top #(
  parameter int ADDR_BITS    = 6,
  parameter int FRAME_BITS   = 4,
  parameter int BACKOFF_BITS = 5
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        auto_run,
  input  logic [1:0]  buf0_src,
  input  logic [1:0]  buf1_src,
  input  logic [31:0] adc0_i,
  input  logic [31:0] adc0_q,
  input  logic [31:0] adc1_i,
  input  logic [31:0] adc1_q,
  input  logic [1:0]  adc0_ovr_i,
  input  logic [1:0]  adc0_ovr_q,
  input  logic [1:0]  adc1_ovr_i,
  input  logic [1:0]  adc1_ovr_q,
  output logic        tx_valid,
  output logic        tx_eof,
  output logic [63:0] tx_data,
  output logic [1:0]  capture_state,
  output logic [15:0] frames_sent,
  output logic [31:0] ovr_count_i0,
  output logic [31:0] ovr_count_q0,
  output logic [31:0] ovr_count_i1,
  output logic [31:0] ovr_count_q1
);

  logic                          write_done;
  logic                          read_done;
  adc_capture_pkg::sample_word_u word0;
  adc_capture_pkg::sample_word_u word1;
  logic                          rd_valid;
  adc_capture_pkg::sample_word_u rd_word0;
  adc_capture_pkg::sample_word_u rd_word1;

  buffer_port_if #(.ADDR_BITS(ADDR_BITS)) buf_port ();

  capture_control #(.BACKOFF_BITS(BACKOFF_BITS)) u_control (
    .clk        (clk),
    .rst        (rst),
    .auto_run   (auto_run),
    .write_done (write_done),
    .read_done  (read_done),
    .phase      (capture_state)
  );

  sample_select u_select (
    .clk      (clk),
    .rst      (rst),
    .buf0_src (buf0_src),
    .buf1_src (buf1_src),
    .adc0_i   (adc0_i),
    .adc0_q   (adc0_q),
    .adc1_i   (adc1_i),
    .adc1_q   (adc1_q),
    .word0    (word0),
    .word1    (word1)
  );

  buffer_sequencer #(.ADDR_BITS(ADDR_BITS)) u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .phase      (capture_state),
    .word0      (word0),
    .word1      (word1),
    .port       (buf_port.seq),
    .write_done (write_done),
    .read_done  (read_done)
  );

  sample_buffer #(.ADDR_BITS(ADDR_BITS)) u_buffer (
    .clk      (clk),
    .port     (buf_port.mem),
    .rd_valid (rd_valid),
    .rd_word0 (rd_word0),
    .rd_word1 (rd_word1)
  );

  frame_packer #(.FRAME_BITS(FRAME_BITS)) u_packer (
    .clk         (clk),
    .rst         (rst),
    .phase       (capture_state),
    .rd_valid    (rd_valid),
    .rd_word0    (rd_word0),
    .rd_word1    (rd_word1),
    .tx_valid    (tx_valid),
    .tx_eof      (tx_eof),
    .tx_data     (tx_data),
    .frames_sent (frames_sent)
  );

  overrange_monitor u_overrange (
    .clk          (clk),
    .rst          (rst),
    .adc0_ovr_i   (adc0_ovr_i),
    .adc0_ovr_q   (adc0_ovr_q),
    .adc1_ovr_i   (adc1_ovr_i),
    .adc1_ovr_q   (adc1_ovr_q),
    .ovr_count_i0 (ovr_count_i0),
    .ovr_count_q0 (ovr_count_q0),
    .ovr_count_i1 (ovr_count_i1),
    .ovr_count_q1 (ovr_count_q1)
  );

endmodule

/* logic/buffer_port_if.sv */
interface buffer_port_if #(
  parameter int ADDR_BITS = 6
);

  logic                         wr_en;
  logic                         rd_en;
  // shared by both strobes, only one is ever high
  logic [ADDR_BITS-1:0]         addr;
  adc_capture_pkg::sample_word_u wr_data0;
  adc_capture_pkg::sample_word_u wr_data1;

  modport seq (
    output wr_en, rd_en, addr, wr_data0, wr_data1
  );

  modport mem (
    input wr_en, rd_en, addr, wr_data0, wr_data1
  );

endinterface

/* logic/buffer_sequencer.sv */
module buffer_sequencer #(
  parameter int ADDR_BITS = 6
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [1:0]                    phase,
  input  adc_capture_pkg::sample_word_u word0,
  input  adc_capture_pkg::sample_word_u word1,
  buffer_port_if.seq                    port,
  output logic                          write_done,
  output logic                          read_done
);

  localparam logic [1:0] W_IDLE   = 2'd0;
  localparam logic [1:0] W_STROBE = 2'd1;
  localparam logic [1:0] W_GAP    = 2'd2;
  localparam logic [1:0] W_DONE   = 2'd3;

  localparam logic [1:0] R_IDLE = 2'd0;
  localparam logic [1:0] R_RUN  = 2'd1;
  localparam logic [1:0] R_DONE = 2'd2;

  // read progress counts cycles, the lsb is the strobe/gap toggle
  localparam logic [ADDR_BITS:0] R_LAST_PROG = {{ADDR_BITS{1'b1}}, 1'b0};

  logic [1:0]           w_state;
  logic [ADDR_BITS-1:0] w_addr;
  logic                 w_last;
  logic [1:0]           r_state;
  logic [ADDR_BITS:0]   r_prog;
  logic                 r_last;
  logic                 wr_strobe;

  // write machine, one write then one gap
  always_ff @(posedge clk) begin
    write_done <= 1'b0;
    w_last     <= &w_addr;
    if (rst) begin
      w_state <= W_IDLE;
      w_addr  <= '0;
    end else begin
      case (w_state)
        W_IDLE: begin
          w_addr <= '0;
          if (phase == adc_capture_pkg::CAP_WRITE) begin
            w_state <= W_STROBE;
          end
        end
        W_STROBE: w_state <= W_GAP;
        W_GAP: begin
          if (w_last) begin
            write_done <= 1'b1;
            w_state    <= W_DONE;
          end else begin
            w_addr  <= w_addr + 1'b1;
            w_state <= W_STROBE;
          end
        end
        // hold until the controller has left the write phase
        default: begin
          if (phase != adc_capture_pkg::CAP_WRITE) begin
            w_state <= W_IDLE;
          end
        end
      endcase
    end
  end

  // read machine, strobe on even progress counts
  always_ff @(posedge clk) begin
    read_done <= 1'b0;
    r_last    <= r_prog == R_LAST_PROG - 1'b1;
    if (rst) begin
      r_state <= R_IDLE;
      r_prog  <= '0;
    end else begin
      case (r_state)
        R_IDLE: begin
          r_prog <= '0;
          if (phase == adc_capture_pkg::CAP_READ) begin
            r_state <= R_RUN;
          end
        end
        R_RUN: begin
          r_prog <= r_prog + 1'b1;
          if (r_last) begin
            read_done <= 1'b1;
            r_state   <= R_DONE;
          end
        end
        default: begin
          if (phase != adc_capture_pkg::CAP_READ) begin
            r_state <= R_IDLE;
          end
        end
      endcase
    end
  end

  assign wr_strobe = w_state == W_STROBE;

  always_comb begin
    port.wr_en    = wr_strobe;
    port.rd_en    = (r_state == R_RUN) && !r_prog[0];
    port.addr     = wr_strobe ? w_addr : r_prog[ADDR_BITS:1];
    port.wr_data0 = word0;
    port.wr_data1 = word1;
  end

endmodule

/* logic/capture_control.sv */
module capture_control #(
  parameter int BACKOFF_BITS = 5
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       auto_run,
  input  logic       write_done,
  input  logic       read_done,
  output logic [1:0] phase
);

  // quiet gap timer, runs only while in backoff
  logic [BACKOFF_BITS-1:0] backoff_timer;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase         <= adc_capture_pkg::CAP_BACKOFF;
      backoff_timer <= '0;
    end else begin
      case (phase)
        adc_capture_pkg::CAP_BACKOFF: begin
          backoff_timer <= backoff_timer + 1'b1;
          // all ones means this is the last backoff cycle
          if (&backoff_timer) begin
            phase <= adc_capture_pkg::CAP_IDLE;
          end
        end

        adc_capture_pkg::CAP_IDLE: begin
          if (auto_run) begin
            phase <= adc_capture_pkg::CAP_WRITE;
          end
        end

        adc_capture_pkg::CAP_WRITE: begin
          if (write_done) begin
            phase <= adc_capture_pkg::CAP_READ;
          end
        end

        adc_capture_pkg::CAP_READ: begin
          if (read_done) begin
            phase         <= adc_capture_pkg::CAP_BACKOFF;
            backoff_timer <= '0;
          end
        end

        default: begin
          phase         <= adc_capture_pkg::CAP_BACKOFF;
          backoff_timer <= '0;
        end
      endcase
    end
  end

endmodule

/* logic/frame_packer.sv */
module frame_packer #(
  parameter int FRAME_BITS = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [1:0]                    phase,
  input  logic                          rd_valid,
  input  adc_capture_pkg::sample_word_u rd_word0,
  input  adc_capture_pkg::sample_word_u rd_word1,
  output logic                          tx_valid,
  output logic                          tx_eof,
  output logic [63:0]                   tx_data,
  output logic [15:0]                   frames_sent
);

  logic [FRAME_BITS-1:0] word_cnt;
  logic                  frame_end;

  // last word of a frame
  assign frame_end = rd_valid && (&word_cnt);

  always_ff @(posedge clk) begin
    tx_data <= {rd_word0.raw, rd_word1.raw};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_valid    <= 1'b0;
      tx_eof      <= 1'b0;
      word_cnt    <= '0;
      frames_sent <= '0;
    end else begin
      tx_valid <= rd_valid;
      tx_eof   <= frame_end;
      // a new capture starts its frames from zero
      if (phase == adc_capture_pkg::CAP_WRITE) begin
        word_cnt <= '0;
      end else if (rd_valid) begin
        word_cnt <= word_cnt + 1'b1;
      end
      if (frame_end) begin
        frames_sent <= frames_sent + 1'b1;
      end
    end
  end

endmodule

/* logic/overrange_monitor.sv */
module overrange_monitor (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  adc0_ovr_i,
  input  logic [1:0]  adc0_ovr_q,
  input  logic [1:0]  adc1_ovr_i,
  input  logic [1:0]  adc1_ovr_q,
  output logic [31:0] ovr_count_i0,
  output logic [31:0] ovr_count_q0,
  output logic [31:0] ovr_count_i1,
  output logic [31:0] ovr_count_q1
);

  // one bit per channel, set if either flag of its pair is up
  logic [3:0]  hit;
  logic [31:0] cnt [4];

  assign hit = {|adc1_ovr_q, |adc1_ovr_i, |adc0_ovr_q, |adc0_ovr_i};

  // plain wrapping counters
  always_ff @(posedge clk) begin
    for (int c = 0; c < 4; c++) begin
      if (rst) begin
        cnt[c] <= '0;
      end else if (hit[c]) begin
        cnt[c] <= cnt[c] + 1'b1;
      end
    end
  end

  assign ovr_count_i0 = cnt[0];
  assign ovr_count_q0 = cnt[1];
  assign ovr_count_i1 = cnt[2];
  assign ovr_count_q1 = cnt[3];

endmodule

/* logic/sample_buffer.sv */
module sample_buffer #(
  parameter int ADDR_BITS = 6
) (
  input  logic                          clk,
  buffer_port_if.mem                    port,
  output logic                          rd_valid,
  output adc_capture_pkg::sample_word_u rd_word0,
  output adc_capture_pkg::sample_word_u rd_word1
);

  localparam int LAT = adc_capture_pkg::BUF_LATENCY;

  logic [31:0] mem0 [2**ADDR_BITS];
  logic [31:0] mem1 [2**ADDR_BITS];

  // read data pipeline, stage 0 is the array output register
  logic [31:0] pipe0 [LAT];
  logic [31:0] pipe1 [LAT];
  logic [LAT-1:0] vld;

  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      mem0[port.addr] <= port.wr_data0.raw;
      mem1[port.addr] <= port.wr_data1.raw;
    end
  end

  always_ff @(posedge clk) begin
    pipe0[0] <= mem0[port.addr];
    pipe1[0] <= mem1[port.addr];
    vld[0]   <= port.rd_en;
    for (int s = 1; s < LAT; s++) begin
      pipe0[s] <= pipe0[s-1];
      pipe1[s] <= pipe1[s-1];
      vld[s]   <= vld[s-1];
    end
  end

  assign rd_valid     = vld[LAT-1];
  assign rd_word0.raw = pipe0[LAT-1];
  assign rd_word1.raw = pipe1[LAT-1];

endmodule

/* logic/sample_select.sv */
module sample_select (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [1:0]                    buf0_src,
  input  logic [1:0]                    buf1_src,
  input  logic [31:0]                   adc0_i,
  input  logic [31:0]                   adc0_q,
  input  logic [31:0]                   adc1_i,
  input  logic [31:0]                   adc1_q,
  output adc_capture_pkg::sample_word_u word0,
  output adc_capture_pkg::sample_word_u word1
);

  logic [1:0] src0_q;
  logic [1:0] src1_q;

  // pick one channel and split it into its four lanes
  function automatic adc_capture_pkg::sample_word_u pick(input logic [1:0] src);
    logic [31:0]                   bus;
    adc_capture_pkg::sample_word_u w;
    case (src)
      adc_capture_pkg::SRC_ADC0_I: bus = adc0_i;
      adc_capture_pkg::SRC_ADC0_Q: bus = adc0_q;
      adc_capture_pkg::SRC_ADC1_I: bus = adc1_i;
      default:                     bus = adc1_q;
    endcase
    for (int n = 0; n < 4; n++) begin
      w.lanes[n] = bus[31-8*n -: 8];
    end
    return w;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      src0_q <= adc_capture_pkg::SRC_ADC0_I;
      src1_q <= adc_capture_pkg::SRC_ADC0_Q;
    end else begin
      src0_q <= buf0_src;
      src1_q <= buf1_src;
    end
  end

  // first pipeline stage
  always_ff @(posedge clk) begin
    word0 <= pick(src0_q);
    word1 <= pick(src1_q);
  end

endmodule

/* sim/adc_capture_tb.sv */
module adc_capture_tb;

  localparam int ADDR_BITS      = 6;
  localparam int FRAME_BITS     = 4;
  localparam int BACKOFF_BITS   = 5;
  localparam int DEPTH          = 2**ADDR_BITS;
  localparam int FRAME_LEN      = 2**FRAME_BITS;
  localparam int BACKOFF_CYCLES = 2**BACKOFF_BITS;
  localparam int RESET_CYCLES   = 5;
  localparam int CAPTURE_CYCLES = BACKOFF_CYCLES + 4*DEPTH + adc_capture_pkg::BUF_LATENCY + 4;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4*CAPTURE_CYCLES + 50;

  logic clk;
  logic rst;
  logic auto_run;
  logic [1:0] buf0_src;
  logic [1:0] buf1_src;
  logic [31:0] adc0_i;
  logic [31:0] adc0_q;
  logic [31:0] adc1_i;
  logic [31:0] adc1_q;
  logic [1:0] adc0_ovr_i;
  logic [1:0] adc0_ovr_q;
  logic [1:0] adc1_ovr_i;
  logic [1:0] adc1_ovr_q;
  logic tx_valid;
  logic tx_eof;
  logic [63:0] tx_data;
  logic [1:0] capture_state;
  logic [15:0] frames_sent;
  logic [31:0] ovr_count [4];

  integer seed = 32'h5c35_7b5b;
  logic ovr_on;
  logic timed_out = 1'b0;
  int checks = 0;
  int errors = 0;

  // reference model state
  logic [1:0] last_state;
  logic [1:0] sel0;
  logic [1:0] sel1;
  int backoff_len;
  int wr_step;
  int rx_count;
  logic [31:0] exp0 [$];
  logic [31:0] exp1 [$];
  logic [31:0] exp_ovr [4];

  adc_capture_top #(
    .ADDR_BITS    (ADDR_BITS),
    .FRAME_BITS   (FRAME_BITS),
    .BACKOFF_BITS (BACKOFF_BITS)
  ) dut (
    .clk           (clk),
    .rst           (rst),
    .auto_run      (auto_run),
    .buf0_src      (buf0_src),
    .buf1_src      (buf1_src),
    .adc0_i        (adc0_i),
    .adc0_q        (adc0_q),
    .adc1_i        (adc1_i),
    .adc1_q        (adc1_q),
    .adc0_ovr_i    (adc0_ovr_i),
    .adc0_ovr_q    (adc0_ovr_q),
    .adc1_ovr_i    (adc1_ovr_i),
    .adc1_ovr_q    (adc1_ovr_q),
    .tx_valid      (tx_valid),
    .tx_eof        (tx_eof),
    .tx_data       (tx_data),
    .capture_state (capture_state),
    .frames_sent   (frames_sent),
    .ovr_count_i0  (ovr_count[0]),
    .ovr_count_q0  (ovr_count[1]),
    .ovr_count_i1  (ovr_count[2]),
    .ovr_count_q1  (ovr_count[3])
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // each flag bit is set about one cycle in eight
  function automatic logic [1:0] rare_pair();
    logic [1:0] r;
    r[0] = ($random(seed) & 7) == 0;
    r[1] = ($random(seed) & 7) == 0;
    return r;
  endfunction

  // lane 0 already sits in the top byte of the raw word
  function automatic logic [31:0] source_word(input logic [1:0] src);
    logic [31:0] w;
    case (src)
      adc_capture_pkg::SRC_ADC0_I: w = adc0_i;
      adc_capture_pkg::SRC_ADC0_Q: w = adc0_q;
      adc_capture_pkg::SRC_ADC1_I: w = adc1_i;
      default:                     w = adc1_q;
    endcase
    return w;
  endfunction

  function automatic logic [1:0] successor(input logic [1:0] s);
    case (s)
      adc_capture_pkg::CAP_BACKOFF: return adc_capture_pkg::CAP_IDLE;
      adc_capture_pkg::CAP_IDLE:    return adc_capture_pkg::CAP_WRITE;
      adc_capture_pkg::CAP_WRITE:   return adc_capture_pkg::CAP_READ;
      default:                      return adc_capture_pkg::CAP_BACKOFF;
    endcase
  endfunction

  task automatic wait_state(input logic [1:0] st);
    do @(posedge clk); while (capture_state != st);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : drive_adc
    adc0_i = '0;
    adc0_q = '0;
    adc1_i = '0;
    adc1_q = '0;
    adc0_ovr_i = '0;
    adc0_ovr_q = '0;
    adc1_ovr_i = '0;
    adc1_ovr_q = '0;
    forever begin
      @(posedge clk);
      adc0_i <= $random(seed);
      adc0_q <= $random(seed);
      adc1_i <= $random(seed);
      adc1_q <= $random(seed);
      adc0_ovr_i <= ovr_on ? rare_pair() : 2'b00;
      adc0_ovr_q <= ovr_on ? rare_pair() : 2'b00;
      adc1_ovr_i <= ovr_on ? rare_pair() : 2'b00;
      adc1_ovr_q <= ovr_on ? rare_pair() : 2'b00;
    end
  end

  // values read here are the ones the DUT samples at this edge
  initial begin : model
    last_state = adc_capture_pkg::CAP_BACKOFF;
    backoff_len = 0;
    wr_step = 2*DEPTH;
    rx_count = 0;
    for (int c = 0; c < 4; c++) begin
      exp_ovr[c] = '0;
    end
    forever begin
      @(posedge clk);
      if (rst) begin
        last_state = adc_capture_pkg::CAP_BACKOFF;
        backoff_len = 0;
      end else begin
        if (capture_state != last_state) begin
          check_value("capture_state", 64'(capture_state), 64'(successor(last_state)));
        end
        if (capture_state == adc_capture_pkg::CAP_BACKOFF) begin
          backoff_len++;
        end else begin
          if (last_state == adc_capture_pkg::CAP_BACKOFF) begin
            check_value("backoff cycles", 64'(backoff_len), 64'(BACKOFF_CYCLES));
          end
          backoff_len = 0;
        end
        // the first edge seen in the write phase is E+1 and writes address 0
        if (capture_state == adc_capture_pkg::CAP_WRITE &&
            last_state != adc_capture_pkg::CAP_WRITE) begin
          wr_step = 0;
          rx_count = 0;
          exp0.delete();
          exp1.delete();
        end
        if (wr_step < 2*DEPTH) begin
          if (wr_step % 2 == 0) begin
            exp0.push_back(source_word(sel0));
            exp1.push_back(source_word(sel1));
          end
          wr_step++;
        end
        if (tx_valid) begin
          if ((capture_state == adc_capture_pkg::CAP_READ ||
               capture_state == adc_capture_pkg::CAP_BACKOFF) && rx_count < exp0.size()) begin
            check_value("tx_data", tx_data, {exp0[rx_count], exp1[rx_count]});
            check_value("tx_eof", 64'(tx_eof), 64'((rx_count % FRAME_LEN) == (FRAME_LEN - 1)));
            rx_count++;
          end else begin
            errors++;
            $display("Error at time %0t: tx_valid is high with no captured word left to send",
                     $time);
          end
        end else begin
          check_value("tx_eof", 64'(tx_eof), 64'(0));
        end
        if (|adc0_ovr_i) exp_ovr[0] = exp_ovr[0] + 32'd1;
        if (|adc0_ovr_q) exp_ovr[1] = exp_ovr[1] + 32'd1;
        if (|adc1_ovr_i) exp_ovr[2] = exp_ovr[2] + 32'd1;
        if (|adc1_ovr_q) exp_ovr[3] = exp_ovr[3] + 32'd1;
        last_state = capture_state;
      end
      // the source registers sit one stage ahead of the word registers
      sel0 = buf0_src;
      sel1 = buf1_src;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = 1'b1;
    $display("Error at time %0t: the captures did not complete within %0d cycles",
             $time, TIMEOUT_CYCLES);
    finish_run();
  end

  task automatic run_capture(inout logic [15:0] used_pairs);
    logic [1:0] s0;
    logic [1:0] s1;
    do begin
      s0 = 2'($random(seed));
      s1 = 2'($random(seed));
    end while (used_pairs[{s0, s1}]);
    used_pairs[{s0, s1}] = 1'b1;
    buf0_src <= s0;
    buf1_src <= s1;
    @(posedge clk);
    auto_run <= 1'b1;
    wait_state(adc_capture_pkg::CAP_WRITE);
    auto_run <= 1'b0;
    wait_state(adc_capture_pkg::CAP_READ);
    wait_state(adc_capture_pkg::CAP_IDLE);
    check_value("words per capture", 64'(rx_count), 64'(DEPTH));
  endtask

  initial begin : stimulus
    logic [15:0] used_pairs;
    used_pairs = '0;
    rst = 1'b1;
    auto_run = 1'b0;
    buf0_src = adc_capture_pkg::SRC_ADC0_I;
    buf1_src = adc_capture_pkg::SRC_ADC0_Q;
    ovr_on = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    ovr_on <= 1'b1;
    @(posedge clk);
    check_value("capture_state", 64'(capture_state), 64'(adc_capture_pkg::CAP_BACKOFF));
    check_value("tx_valid", 64'(tx_valid), 64'(0));
    check_value("frames_sent", 64'(frames_sent), 64'(0));
    wait_state(adc_capture_pkg::CAP_IDLE);
    // no capture may start while auto_run is low
    repeat (200) begin
      @(posedge clk);
      check_value("capture_state", 64'(capture_state), 64'(adc_capture_pkg::CAP_IDLE));
      check_value("tx_valid", 64'(tx_valid), 64'(0));
    end
    repeat (3) run_capture(used_pairs);
    check_value("frames_sent", 64'(frames_sent), 64'(3 * DEPTH / FRAME_LEN));
    ovr_on <= 1'b0;
    repeat (10) @(posedge clk);
    check_value("ovr_count_i0", 64'(ovr_count[0]), 64'(exp_ovr[0]));
    check_value("ovr_count_q0", 64'(ovr_count[1]), 64'(exp_ovr[1]));
    check_value("ovr_count_i1", 64'(ovr_count[2]), 64'(exp_ovr[2]));
    check_value("ovr_count_q1", 64'(ovr_count[3]), 64'(exp_ovr[3]));
    finish_run();
  end

endmodule
